// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    // major opcodes, bits [6:2]
    localparam logic [4:0] OPC_LOAD     = 5'b00000;
    localparam logic [4:0] OPC_STORE    = 5'b01000;
    localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPC_OP       = 5'b01100;
    localparam logic [4:0] OPC_LUI      = 5'b01101;
    localparam logic [4:0] OPC_AUIPC    = 5'b00101;
    localparam logic [4:0] OPC_BRANCH   = 5'b11000;
    localparam logic [4:0] OPC_JAL      = 5'b11011;
    localparam logic [4:0] OPC_JALR     = 5'b11001;
    localparam logic [4:0] OPC_MISC_MEM = 5'b00011;

    localparam logic [1:0] OPC_FULL     = 2'b11; // non-compressed encoding

    localparam logic [6:0] F7_BASE      = 7'b0000000;
    localparam logic [6:0] F7_ALT       = 7'b0100000; // sub / sra / srai

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // also the B layout, bits get shuffled later
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // also the J layout
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        logic [XLEN-1:0] raw;
        r_fmt_t          r;
        i_fmt_t          i;
        s_fmt_t          s;
        u_fmt_t          u;
    } instr_u;

    typedef struct packed {
        instr_u          instr;
        logic [XLEN-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic load;
        logic store;
        logic op_imm;
        logic op_reg;
        logic lui;
        logic auipc;
        logic branch;
        logic jal;
        logic jalr;
        logic fence;
    } inst_class_t;

    typedef struct packed {
        logic op1_pc;
        logic op1_reg;
        logic op2_imm;
        logic op2_reg;
        logic op2_j;
    } op_src_t;

    typedef struct packed {
        logic memory;
        logic pc_p4;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic res_cmp;
        logic res_bits;
        logic res_shift;
        logic res_arith;
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;  // bne, bge, bgeu
        logic bits_and;
        logic bits_or;
        logic bits_xor;
        logic arith_add;
        logic arith_sub;
        logic arith_shl;
        logic arith_shr;
        logic shift_arithmetical;
    } alu_ctrl_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_j;
        op_src_t         op_src;
        res_src_t        res_src;
        alu_ctrl_t       alu_ctrl;
        logic            reg_write;
        logic            inst_jal;
        logic            inst_jalr;
        logic            inst_branch;
        logic            inst_store;
        logic            supported;
        logic [2:0]      funct3;
        logic [XLEN-1:0] pc;
    } dec_t;

endpackage

`default_nettype wire

// ==== rv_inst_class.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_inst_class (
    input  rv_pkg::instr_u      i_instr,
    output rv_pkg::inst_class_t o_class,
    output rv_pkg::op_src_t     o_op_src,
    output rv_pkg::res_src_t    o_res_src,
    output logic                o_reg_write,
    output logic                o_supported
);

    logic       full;
    logic [4:0] opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_base;
    logic       f7_alt;
    logic       shift_ok;
    logic       reg_ok;
    logic       br_ok;
    logic       ld_ok;
    logic       st_ok;
    logic       imm_op2;

    assign full    = (i_instr.r.opcode[1:0] == rv_pkg::OPC_FULL);
    assign opc     = i_instr.r.opcode[6:2];
    assign funct3  = i_instr.r.funct3;
    assign funct7  = i_instr.r.funct7;
    assign f7_base = (funct7 == rv_pkg::F7_BASE);
    assign f7_alt  = (funct7 == rv_pkg::F7_ALT);

    // shift immediates keep funct7 in imm[11:5]
    always_comb begin
        case (funct3)
            3'b001:  shift_ok = f7_base;
            3'b101:  shift_ok = f7_base | f7_alt;
            default: shift_ok = 1'b1;
        endcase
    end

    // alt form only exists for sub and sra
    assign reg_ok = f7_base | (f7_alt & ((funct3 == 3'b000) | (funct3 == 3'b101)));

    always_comb begin
        o_class.load   = full & (opc == rv_pkg::OPC_LOAD);
        o_class.store  = full & (opc == rv_pkg::OPC_STORE);
        o_class.op_imm = full & (opc == rv_pkg::OPC_OP_IMM) & shift_ok;
        o_class.op_reg = full & (opc == rv_pkg::OPC_OP) & reg_ok;
        o_class.lui    = full & (opc == rv_pkg::OPC_LUI);
        o_class.auipc  = full & (opc == rv_pkg::OPC_AUIPC);
        o_class.branch = full & (opc == rv_pkg::OPC_BRANCH);
        o_class.jal    = full & (opc == rv_pkg::OPC_JAL);
        o_class.jalr   = full & (opc == rv_pkg::OPC_JALR) & (funct3 == 3'b000);
        // fence and fence.i
        o_class.fence  = full & (opc == rv_pkg::OPC_MISC_MEM) & (funct3[2:1] == 2'b00);
    end

    assign imm_op2 = o_class.jalr | o_class.load | o_class.op_imm | o_class.lui
                   | o_class.auipc | o_class.store;

    always_comb begin
        o_op_src.op1_pc  = o_class.auipc | o_class.jal;
        o_op_src.op1_reg = ~(o_class.auipc | o_class.jal);
        o_op_src.op2_imm = imm_op2;
        o_op_src.op2_reg = ~(imm_op2 | o_class.jal);
        o_op_src.op2_j   = o_class.jal;
    end

    always_comb begin
        o_res_src.memory = o_class.load;
        o_res_src.pc_p4  = o_class.jal | o_class.jalr;   // link address
        o_res_src.alu    = ~(o_class.load | o_class.jal | o_class.jalr);
    end

    assign o_reg_write = o_class.load | o_class.op_imm | o_class.auipc | o_class.op_reg
                       | o_class.lui | o_class.jalr | o_class.jal;

    // funct3 holes of branch, load and store
    assign br_ok = o_class.branch & (funct3[2:1] != 2'b01);
    assign ld_ok = o_class.load & (funct3 != 3'b011) & (funct3[2:1] != 2'b11);
    assign st_ok = o_class.store & ~funct3[2] & (funct3[1:0] != 2'b11);

    assign o_supported = o_class.op_imm | o_class.op_reg | o_class.lui | o_class.auipc
                       | o_class.jal | o_class.jalr | o_class.fence
                       | br_ok | ld_ok | st_ok
                       | (i_instr.raw == '0);  // zero word treated as nop

endmodule

`default_nettype wire

// ==== rv_alu_ctrl_enc.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu_ctrl_enc (
    input  rv_pkg::inst_class_t i_class,
    input  wire [2:0]           i_funct3,
    input  wire                 i_funct7_alt,
    output rv_pkg::alu_ctrl_t   o_alu_ctrl
);

    logic alu;     // op or op-imm
    logic f3_add;
    logic f3_sll;
    logic f3_slt;
    logic f3_sltu;
    logic f3_xor;
    logic f3_sr;
    logic f3_or;
    logic f3_and;
    logic sub;

    assign alu     = i_class.op_imm | i_class.op_reg;
    assign f3_add  = (i_funct3 == 3'b000);
    assign f3_sll  = (i_funct3 == 3'b001);
    assign f3_slt  = (i_funct3 == 3'b010);
    assign f3_sltu = (i_funct3 == 3'b011);
    assign f3_xor  = (i_funct3 == 3'b100);
    assign f3_sr   = (i_funct3 == 3'b101);
    assign f3_or   = (i_funct3 == 3'b110);
    assign f3_and  = (i_funct3 == 3'b111);

    // bit 30 is part of the immediate for addi
    assign sub = i_class.op_reg & f3_add & i_funct7_alt;

    always_comb begin
        o_alu_ctrl.res_cmp   = i_class.branch | (alu & (f3_slt | f3_sltu));
        o_alu_ctrl.res_bits  = alu & (f3_xor | f3_or | f3_and);
        o_alu_ctrl.res_shift = alu & (f3_sll | f3_sr);
        o_alu_ctrl.res_arith = alu & f3_add;

        // beq/bne, blt/bge, bltu/bgeu pair up on funct3[2:1]
        o_alu_ctrl.cmp_eq       = i_class.branch & (i_funct3[2:1] == 2'b00);
        o_alu_ctrl.cmp_lts      = (alu & f3_slt)
                                | (i_class.branch & (i_funct3[2:1] == 2'b10));
        o_alu_ctrl.cmp_ltu      = (alu & f3_sltu)
                                | (i_class.branch & (i_funct3[2:1] == 2'b11));
        o_alu_ctrl.cmp_inversed = i_class.branch & i_funct3[0];

        o_alu_ctrl.bits_and = alu & f3_and;
        o_alu_ctrl.bits_or  = alu & f3_or;
        o_alu_ctrl.bits_xor = alu & f3_xor;

        o_alu_ctrl.arith_add          = alu & f3_add & ~sub;
        o_alu_ctrl.arith_sub          = sub;
        o_alu_ctrl.arith_shl          = alu & f3_sll;
        o_alu_ctrl.arith_shr          = alu & f3_sr;
        o_alu_ctrl.shift_arithmetical = alu & f3_sr & i_funct7_alt; // sra, srai
    end

endmodule

`default_nettype wire

// ==== rv_imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
    input  rv_pkg::instr_u             i_instr,
    input  rv_pkg::inst_class_t        i_class,
    output logic [rv_pkg::XLEN-1:0]    o_imm_i,
    output logic [rv_pkg::XLEN-1:0]    o_imm_j
);

    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_j;

    assign imm_i = {{20{i_instr.i.imm12[11]}}, i_instr.i.imm12};
    assign imm_s = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};

    // imm_lo[0] is b[11], imm_hi[6] the sign
    assign imm_b = {{19{i_instr.s.imm_hi[6]}},
                    i_instr.s.imm_hi[6],
                    i_instr.s.imm_lo[0],
                    i_instr.s.imm_hi[5:0],
                    i_instr.s.imm_lo[4:1],
                    1'b0};

    assign imm_u = {i_instr.u.imm20, 12'b0};

    assign imm_j = {{11{i_instr.u.imm20[19]}},
                    i_instr.u.imm20[19],
                    i_instr.u.imm20[7:0],    // j[19:12]
                    i_instr.u.imm20[8],      // j[11]
                    i_instr.u.imm20[18:9],   // j[10:1]
                    1'b0};

    always_comb begin
        if (i_class.lui | i_class.auipc) begin
            o_imm_i = imm_u;
        end else if (i_class.store) begin
            o_imm_i = imm_s;
        end else begin
            o_imm_i = imm_i;
        end
    end

    assign o_imm_j = i_class.jal ? imm_j : imm_b;

endmodule

`default_nettype wire

// ==== rv_decode_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode_reg #(
    parameter int P_PC_W = 32
) (
    input  wire                          i_clk,
    input  wire                          i_arst_n,
    input  rv_pkg::instr_u               i_instr,
    input  wire [P_PC_W-1:0]             i_pc,
    input  rv_pkg::inst_class_t          i_class,
    input  rv_pkg::op_src_t              i_op_src,
    input  rv_pkg::res_src_t             i_res_src,
    input  rv_pkg::alu_ctrl_t            i_alu_ctrl,
    input  wire                          i_reg_write,
    input  wire                          i_supported,
    input  wire [rv_pkg::XLEN-1:0]       i_imm_i,
    input  wire [rv_pkg::XLEN-1:0]       i_imm_j,
    output rv_pkg::dec_t                 o_dec
);

    rv_pkg::dec_t dec_d;

    always_comb begin
        dec_d.rd  = i_instr.r.rd;
        dec_d.rs1 = i_class.lui ? 5'd0 : i_instr.r.rs1;  // lui reads x0
        dec_d.rs2 = i_instr.r.rs2;

        dec_d.imm_i    = i_imm_i;
        dec_d.imm_j    = i_imm_j;
        dec_d.op_src   = i_op_src;
        dec_d.res_src  = i_res_src;
        dec_d.alu_ctrl = i_alu_ctrl;

        dec_d.reg_write   = i_reg_write;
        dec_d.inst_jal    = i_class.jal;
        dec_d.inst_jalr   = i_class.jalr;
        dec_d.inst_branch = i_class.branch;
        dec_d.inst_store  = i_class.store;
        dec_d.supported   = i_supported;

        dec_d.funct3 = i_instr.r.funct3;
        dec_d.pc     = rv_pkg::XLEN'(i_pc);  // upper bits zero
    end

    // whole word registered so every field lines up with pc
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_dec <= '0;
        end else begin
            o_dec <= dec_d;
        end
    end

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode #(
    parameter int P_PC_W = 32
) (
    input  wire            i_clk,
    input  wire            i_arst_n,
    input  rv_pkg::fetch_t i_fetch,
    output rv_pkg::dec_t   o_dec
);

    rv_pkg::inst_class_t     inst_class;
    rv_pkg::op_src_t         op_src;
    rv_pkg::res_src_t        res_src;
    rv_pkg::alu_ctrl_t       alu_ctrl;
    logic                    reg_write;
    logic                    supported;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_j;

    rv_inst_class u_inst_class (
        .i_instr     (i_fetch.instr),
        .o_class     (inst_class),
        .o_op_src    (op_src),
        .o_res_src   (res_src),
        .o_reg_write (reg_write),
        .o_supported (supported)
    );

    rv_alu_ctrl_enc u_alu_ctrl_enc (
        .i_class      (inst_class),
        .i_funct3     (i_fetch.instr.r.funct3),
        .i_funct7_alt (i_fetch.instr.raw[30]),
        .o_alu_ctrl   (alu_ctrl)
    );

    rv_imm_gen u_imm_gen (
        .i_instr (i_fetch.instr),
        .i_class (inst_class),
        .o_imm_i (imm_i),
        .o_imm_j (imm_j)
    );

    rv_decode_reg #(
        .P_PC_W (P_PC_W)
    ) u_decode_reg (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_instr     (i_fetch.instr),
        .i_pc        (i_fetch.pc[P_PC_W-1:0]),
        .i_class     (inst_class),
        .i_op_src    (op_src),
        .i_res_src   (res_src),
        .i_alu_ctrl  (alu_ctrl),
        .i_reg_write (reg_write),
        .i_supported (supported),
        .i_imm_i     (imm_i),
        .i_imm_j     (imm_j),
        .o_dec       (o_dec)
    );

endmodule

`default_nettype wire

// ==== rv_decode_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode_props #(
    parameter int P_PC_W = 32
) (
    input wire            i_clk,
    input wire            i_arst_n,
    input rv_pkg::fetch_t i_fetch,
    input rv_pkg::dec_t   i_dec
);

    int             fail_count = 0;
    logic           armed;       // first edge after reset has nothing to compare
    rv_pkg::fetch_t past_fetch;
    rv_pkg::dec_t   want;
    logic [13:0]    ctrl_want;
    logic [13:0]    ctrl_got;

    // reference decode straight from the ISA bit positions
    function automatic rv_pkg::dec_t expect_dec(input rv_pkg::fetch_t f);
        rv_pkg::dec_t        d;
        rv_pkg::inst_class_t c;
        logic [31:0]         w;
        logic [2:0]          f3;
        logic [6:0]          f7;
        logic                base;
        logic                alt;
        logic                alu;
        d = '0;
        c = '0;
        w = f.instr.raw;
        f3 = w[14:12];
        f7 = w[31:25];
        base = (f7 == rv_pkg::F7_BASE);
        alt = (f7 == rv_pkg::F7_ALT);
        if (w[1:0] == rv_pkg::OPC_FULL) begin
            case (w[6:2])
                rv_pkg::OPC_LOAD:     c.load = 1'b1;
                rv_pkg::OPC_STORE:    c.store = 1'b1;
                rv_pkg::OPC_OP_IMM:   c.op_imm = (f3 == 3'd1) ? base
                                               : ((f3 != 3'd5) || base || alt);
                rv_pkg::OPC_OP:       c.op_reg = base || (alt && (f3 == 3'd0 || f3 == 3'd5));
                rv_pkg::OPC_LUI:      c.lui = 1'b1;
                rv_pkg::OPC_AUIPC:    c.auipc = 1'b1;
                rv_pkg::OPC_BRANCH:   c.branch = 1'b1;
                rv_pkg::OPC_JAL:      c.jal = 1'b1;
                rv_pkg::OPC_JALR:     c.jalr = (f3 == 3'd0);
                rv_pkg::OPC_MISC_MEM: c.fence = (f3 <= 3'd1);
                default: ;
            endcase
        end
        alu = c.op_imm | c.op_reg;

        d.rd = w[11:7];
        d.rs1 = c.lui ? 5'd0 : w[19:15];
        d.rs2 = w[24:20];
        d.funct3 = f3;
        d.pc = f.pc & ~({rv_pkg::XLEN{1'b1}} << P_PC_W);

        if (c.lui || c.auipc) begin
            d.imm_i = {w[31:12], 12'b0};
        end else if (c.store) begin
            d.imm_i = {{20{w[31]}}, w[31:25], w[11:7]};
        end else begin
            d.imm_i = {{20{w[31]}}, w[31:20]};
        end
        if (c.jal) begin
            d.imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end else begin
            d.imm_j = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end

        d.op_src.op1_pc = c.auipc | c.jal;
        d.op_src.op1_reg = !(c.auipc | c.jal);
        d.op_src.op2_imm = c.jalr | c.load | c.op_imm | c.lui | c.auipc | c.store;
        d.op_src.op2_j = c.jal;
        d.op_src.op2_reg = !(c.jal | c.lui | c.auipc | c.jalr | c.load | c.op_imm | c.store);
        d.res_src.memory = c.load;
        d.res_src.pc_p4 = c.jal | c.jalr;
        d.res_src.alu = !(c.load | c.jal | c.jalr);

        d.reg_write = c.load | alu | c.auipc | c.lui | c.jalr | c.jal;
        d.inst_jal = c.jal;
        d.inst_jalr = c.jalr;
        d.inst_branch = c.branch;
        d.inst_store = c.store;
        d.supported = alu | c.lui | c.auipc | c.jal | c.jalr | c.fence
                    | (c.branch && !(f3 inside {3'd2, 3'd3}))
                    | (c.load && (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}))
                    | (c.store && f3 <= 3'd2)
                    | (w == 32'h0);

        d.alu_ctrl.res_cmp = c.branch | (alu && (f3 == 3'd2 || f3 == 3'd3));
        d.alu_ctrl.res_bits = alu && (f3 inside {3'd4, 3'd6, 3'd7});
        d.alu_ctrl.res_shift = alu && (f3 == 3'd1 || f3 == 3'd5);
        d.alu_ctrl.res_arith = alu && f3 == 3'd0;
        d.alu_ctrl.cmp_eq = c.branch && f3 <= 3'd1;
        d.alu_ctrl.cmp_lts = (alu && f3 == 3'd2) | (c.branch && (f3 inside {3'd4, 3'd5}));
        d.alu_ctrl.cmp_ltu = (alu && f3 == 3'd3) | (c.branch && f3 >= 3'd6);
        d.alu_ctrl.cmp_inversed = c.branch & f3[0];
        d.alu_ctrl.bits_and = alu && f3 == 3'd7;
        d.alu_ctrl.bits_or = alu && f3 == 3'd6;
        d.alu_ctrl.bits_xor = alu && f3 == 3'd4;
        d.alu_ctrl.arith_sub = c.op_reg && f3 == 3'd0 && w[30];  // addi has no alternate form
        d.alu_ctrl.arith_add = alu && f3 == 3'd0 && !d.alu_ctrl.arith_sub;
        d.alu_ctrl.arith_shl = alu && f3 == 3'd1;
        d.alu_ctrl.arith_shr = alu && f3 == 3'd5;
        d.alu_ctrl.shift_arithmetical = alu && f3 == 3'd5 && w[30];
        return d;
    endfunction

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        past_fetch <= i_fetch;
    end

    assign want = expect_dec(past_fetch);

    assign ctrl_want = {want.op_src, want.res_src, want.reg_write, want.inst_jal,
                        want.inst_jalr, want.inst_branch, want.inst_store, want.supported};
    assign ctrl_got  = {i_dec.op_src, i_dec.res_src, i_dec.reg_write, i_dec.inst_jal,
                        i_dec.inst_jalr, i_dec.inst_branch, i_dec.inst_store, i_dec.supported};

    // mid-cycle so that it also covers the gap between release and first edge
    a_zero: assert property (@(negedge i_clk) !armed |-> i_dec == '0)
        else begin
            fail_count++;
            $error("[ERROR] o_dec exp %h act %h", rv_pkg::dec_t'(0), $sampled(i_dec));
        end

    a_ctrl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        armed |-> ctrl_got == ctrl_want)
        else begin
            fail_count++;
            $error("[ERROR] ctrl/src/supported exp %h act %h",
                   $sampled(ctrl_want), $sampled(ctrl_got));
        end

    a_alu: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        armed |-> i_dec.alu_ctrl == want.alu_ctrl)
        else begin
            fail_count++;
            $error("[ERROR] alu_ctrl exp %h act %h",
                   $sampled(want.alu_ctrl), $sampled(i_dec.alu_ctrl));
        end

    a_imm_i: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        armed |-> i_dec.imm_i == want.imm_i)
        else begin
            fail_count++;
            $error("[ERROR] imm_i exp %h act %h", $sampled(want.imm_i), $sampled(i_dec.imm_i));
        end

    a_imm_j: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        armed |-> i_dec.imm_j == want.imm_j)
        else begin
            fail_count++;
            $error("[ERROR] imm_j exp %h act %h", $sampled(want.imm_j), $sampled(i_dec.imm_j));
        end

    a_fields: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        armed |-> {i_dec.rd, i_dec.rs1, i_dec.rs2, i_dec.funct3}
               == {want.rd, want.rs1, want.rs2, want.funct3})
        else begin
            fail_count++;
            $error("[ERROR] rd/rs1/rs2/funct3 exp %h act %h",
                   $sampled({want.rd, want.rs1, want.rs2, want.funct3}),
                   $sampled({i_dec.rd, i_dec.rs1, i_dec.rs2, i_dec.funct3}));
        end

    a_pc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        armed |-> i_dec.pc == want.pc)
        else begin
            fail_count++;
            $error("[ERROR] pc exp %h act %h", $sampled(want.pc), $sampled(i_dec.pc));
        end

endmodule

bind rv_decode rv_decode_props #(
    .P_PC_W (P_PC_W)
) u_props (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_fetch  (i_fetch),
    .i_dec    (o_dec)
);

`default_nettype wire

// ==== tb_rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode;

    localparam int N_RAND  = 200;
    // words per test, one flush cycle each, reset cycles included
    localparam int N_WORDS = 3 + 41 + 17 + 13 + 8 + (N_RAND + 2);

    logic           clk = 1'b0;
    logic           arst_n;
    rv_pkg::fetch_t fetch;
    rv_pkg::dec_t   dec;
    logic [31:0]    lfsr_state;
    logic [31:0]    pc;
    int             mark;
    int             n_pass;
    int             n_fail;

    rv_decode #(
        .P_PC_W (32)
    ) DUT (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_fetch  (fetch),
        .o_dec    (dec)
    );

    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // funct7 and register fields random
    function automatic logic [31:0] rand_word(input logic [2:0] f3, input logic [4:0] opc);
        logic [31:0] r;
        r = take_bits(22);
        return {r[21:5], f3, r[4:0], opc, 2'b11};
    endfunction

    task automatic send(input logic [31:0] w);
        fetch.instr.raw = w;
        fetch.pc = pc;
        pc = pc + 32'd4;
        @(posedge clk);
        #1;
    endtask

    task automatic send_f7(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] opc);
        logic [31:0] w;
        w = rand_word(f3, opc);
        w[31:25] = f7;
        send(w);
    endtask

    task automatic end_test(input string name);
        int added;
        @(posedge clk);  // last word gets checked here
        #1;
        added = DUT.u_props.fail_count - mark;
        mark = DUT.u_props.fail_count;
        $display("test %s: %0d failures", name, added);
        if (added == 0) begin
            n_pass++;
        end else begin
            n_fail++;
        end
    endtask

    initial begin
        #(N_WORDS * 20 * 2);
        $display("timeout: the decode tests did not finish in time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [31:0] w;
        arst_n = 1'b0;
        fetch = '0;
        pc = 32'h0000_1000;
        lfsr_state = 32'h3339;
        mark = 0;
        n_pass = 0;
        n_fail = 0;

        fetch.instr.raw = take_bits(32);  // must stay hidden behind reset
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        end_test("reset");

        for (int k = 0; k < 8; k++) begin
            send_f7(rv_pkg::F7_BASE, 3'(k), rv_pkg::OPC_OP);
            send_f7(rv_pkg::F7_ALT, 3'(k), rv_pkg::OPC_OP);
            send_f7(rv_pkg::F7_BASE, 3'(k), rv_pkg::OPC_OP_IMM);
            send_f7(rv_pkg::F7_ALT, 3'(k), rv_pkg::OPC_OP_IMM);
            send(rand_word(3'(k), rv_pkg::OPC_OP_IMM));
        end
        end_test("alu_ops");

        for (int k = 0; k < 8; k++) begin
            send(rand_word(3'(k), rv_pkg::OPC_LOAD));
            send(rand_word(3'(k), rv_pkg::OPC_STORE));
        end
        end_test("load_store");

        for (int k = 0; k < 8; k++) begin
            send(rand_word(3'(k), rv_pkg::OPC_BRANCH));
        end
        send(rand_word(3'd0, rv_pkg::OPC_JAL));
        send(rand_word(3'd5, rv_pkg::OPC_JAL));
        send(rand_word(3'd0, rv_pkg::OPC_JALR));
        send(rand_word(3'd2, rv_pkg::OPC_JALR));  // not a jalr
        end_test("branch_jump");

        for (int k = 0; k < 2; k++) begin
            pc = take_bits(32);
            send(rand_word(3'(k), rv_pkg::OPC_LUI));
            pc = take_bits(32);
            send(rand_word(3'(k), rv_pkg::OPC_AUIPC));
        end
        for (int k = 0; k < 3; k++) begin
            pc = take_bits(32);
            send(rand_word(3'(k), rv_pkg::OPC_MISC_MEM));
        end
        end_test("upper_fence_pc");

        for (int k = 0; k < N_RAND; k++) begin
            w = take_bits(32);
            if (k % 2 == 0) begin
                w[1:0] = 2'b11;  // half as full-length encodings
            end
            send(w);
        end
        send(32'h0);
        end_test("random");

        $display("tests passed %0d failed %0d, assertion failures %0d",
                 n_pass, n_fail, DUT.u_props.fail_count);
        if (n_fail == 0 && DUT.u_props.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rv_pkg.sv
rv_inst_class.sv
rv_alu_ctrl_enc.sv
rv_imm_gen.sv
rv_decode_reg.sv
rv_decode.sv
rv_decode_props.sv
tb_rv_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the decode stage testbench with Verilator

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module tb_rv_decode -f build.f \
    -o sim_rv_decode > "$LOG" 2>&1 &&
./obj_dir/sim_rv_decode +verilator+error+limit+1000 >> "$LOG" 2>&1 ||
{ cat "$LOG"; echo "build or simulation failed"; exit 1; }

cat "$LOG"

grep -q "Regression failed" "$LOG" && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
